// File: Makefile
# Verilator build and run of the memory node testbench
TOP := mc_node_tb

all: run

obj_dir/V$(TOP): flist.f $(wildcard hw/*.sv hw/*.svh verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: flist.f
+incdir+hw
hw/mc_pkg.sv
hw/mc_remote_endpoint.sv
hw/mc_link_fifo.sv
hw/mc_dram_model.sv
hw/mc_vcache.sv
hw/mc_node_top.sv
verification/mc_link_fifo_checker.sv
verification/mc_node_tb.sv

// File: hw/mc_consts.svh
// sizes for the whole node; MC_SETS, MC_BLOCK_WORDS and MC_FIFO_DEPTH must be powers of two
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// packet field widths
`define MC_DATA_W 32
// word address, not byte address
`define MC_ADDR_W 12
`define MC_ID_W 6

// link buffer entries, equal to the credits held by the endpoint
`define MC_FIFO_DEPTH 4

// direct mapped, so one line per set
`define MC_SETS 8
`define MC_BLOCK_WORDS 4

// backing store covers the full word address space
`define MC_DRAM_WORDS 4096
// cycles from read strobe to block valid
`define MC_DRAM_LAT 5

`endif

// File: hw/mc_dram_model.sv
// simulation memory, zero at time 0; reads see writes made while the read is in flight
`include "mc_consts.svh"

module mc_dram_model (
  input  logic                                             clk,
  input  logic                                             rd_v_i,
  input  logic [`MC_ADDR_W-$clog2(`MC_BLOCK_WORDS)-1:0]    rd_addr_i,
  output logic                                             rd_done_o,
  output logic [`MC_BLOCK_WORDS-1:0][`MC_DATA_W-1:0]       rd_block_o,
  input  logic                                             wr_v_i,
  input  logic [`MC_ADDR_W-1:0]                            wr_addr_i,
  input  logic [`MC_DATA_W-1:0]                            wr_data_i
);

  localparam int OFF_W = $clog2(`MC_BLOCK_WORDS);
  localparam int BLK_W = `MC_ADDR_W - OFF_W;

  logic [`MC_DATA_W-1:0] mem [`MC_DRAM_WORDS] = '{default: '0};

  // read latency pipeline
  logic [`MC_DRAM_LAT-1:0] rd_v_pipe = '0;
  logic [BLK_W-1:0]        rd_addr_pipe [`MC_DRAM_LAT];

  always_ff @(posedge clk) begin
    rd_v_pipe[0]    <= rd_v_i;
    rd_addr_pipe[0] <= rd_addr_i;
    for (int i = 1; i < `MC_DRAM_LAT; i++) begin
      rd_v_pipe[i]    <= rd_v_pipe[i-1];
      rd_addr_pipe[i] <= rd_addr_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_v_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  assign rd_done_o = rd_v_pipe[`MC_DRAM_LAT-1];

  always_comb begin
    for (int k = 0; k < `MC_BLOCK_WORDS; k++) begin
      rd_block_o[k] = mem[{rd_addr_pipe[`MC_DRAM_LAT-1], OFF_W'(k)}];
    end
  end

endmodule

// File: hw/mc_link_fifo.sv
// no overflow or underflow guard; the producer's credits keep pushes within MC_FIFO_DEPTH
`include "mc_consts.svh"

module mc_link_fifo
  import mc_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push_i,
  input  mc_op_e                push_op_i,
  input  logic [`MC_ID_W-1:0]   push_id_i,
  input  logic [`MC_ADDR_W-1:0] push_addr_i,
  input  logic [`MC_DATA_W-1:0] push_data_i,
  input  logic                  pop_i,
  output logic                  empty_o,
  output mc_op_e                head_op_o,
  output logic [`MC_ID_W-1:0]   head_id_o,
  output logic [`MC_ADDR_W-1:0] head_addr_o,
  output logic [`MC_DATA_W-1:0] head_data_o,
  output logic                  credit_return_o
);

  localparam int PTR_W = $clog2(`MC_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`MC_FIFO_DEPTH + 1);

  mc_op_e                op_mem   [`MC_FIFO_DEPTH];
  logic [`MC_ID_W-1:0]   id_mem   [`MC_FIFO_DEPTH];
  logic [`MC_ADDR_W-1:0] addr_mem [`MC_FIFO_DEPTH];
  logic [`MC_DATA_W-1:0] data_mem [`MC_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`MC_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop_i) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      if (push_i && !pop_i) begin
        count_r <= count_r + 1'b1;
      end else if (!push_i && pop_i) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      op_mem[wr_ptr_r]   <= push_op_i;
      id_mem[wr_ptr_r]   <= push_id_i;
      addr_mem[wr_ptr_r] <= push_addr_i;
      data_mem[wr_ptr_r] <= push_data_i;
    end
  end

  assign empty_o     = (count_r == '0);
  assign head_op_o   = op_mem[rd_ptr_r];
  assign head_id_o   = id_mem[rd_ptr_r];
  assign head_addr_o = addr_mem[rd_ptr_r];
  assign head_data_o = data_mem[rd_ptr_r];

  // slot freed at the pop edge
  assign credit_return_o = pop_i;

endmodule

// File: hw/mc_node_top.sv
// single memory node; responses leave in request order, host must honor req_full_o
`include "mc_consts.svh"

module mc_node_top
  import mc_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_v_i,
  input  mc_op_e                req_op_i,
  input  logic [`MC_ADDR_W-1:0] req_addr_i,
  input  logic [`MC_DATA_W-1:0] req_data_i,
  output logic                  req_full_o,
  output logic                  resp_v_o,
  output logic [`MC_ID_W-1:0]   resp_id_o,
  output mc_op_e                resp_op_o,
  output logic [`MC_DATA_W-1:0] resp_data_o,
  output logic                  resp_hit_o
);

  // endpoint to link
  logic                  push;
  mc_op_e                push_op;
  logic [`MC_ID_W-1:0]   push_id;
  logic [`MC_ADDR_W-1:0] push_addr;
  logic [`MC_DATA_W-1:0] push_data;
  logic                  credit_return;

  // link to vcache
  logic                  empty;
  logic                  pop;
  mc_op_e                head_op;
  logic [`MC_ID_W-1:0]   head_id;
  logic [`MC_ADDR_W-1:0] head_addr;
  logic [`MC_DATA_W-1:0] head_data;

  mc_remote_endpoint i_endpoint (
    .clk             (clk),
    .reset           (reset),
    .req_v_i         (req_v_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .req_data_i      (req_data_i),
    .credit_return_i (credit_return),
    .req_full_o      (req_full_o),
    .push_o          (push),
    .push_op_o       (push_op),
    .push_id_o       (push_id),
    .push_addr_o     (push_addr),
    .push_data_o     (push_data)
  );

  mc_link_fifo i_link (
    .clk             (clk),
    .reset           (reset),
    .push_i          (push),
    .push_op_i       (push_op),
    .push_id_i       (push_id),
    .push_addr_i     (push_addr),
    .push_data_i     (push_data),
    .pop_i           (pop),
    .empty_o         (empty),
    .head_op_o       (head_op),
    .head_id_o       (head_id),
    .head_addr_o     (head_addr),
    .head_data_o     (head_data),
    .credit_return_o (credit_return)
  );

  mc_vcache i_vcache (
    .clk         (clk),
    .reset       (reset),
    .empty_i     (empty),
    .head_op_i   (head_op),
    .head_id_i   (head_id),
    .head_addr_i (head_addr),
    .head_data_i (head_data),
    .pop_o       (pop),
    .resp_v_o    (resp_v_o),
    .resp_id_o   (resp_id_o),
    .resp_op_o   (resp_op_o),
    .resp_data_o (resp_data_o),
    .resp_hit_o  (resp_hit_o)
  );

endmodule

// File: hw/mc_pkg.sv
// opcode and vcache FSM encodings; the state encoding is fixed at 2 bits
package mc_pkg;

  // one bit on the link
  typedef enum logic {
    MC_OP_LOAD  = 1'b0,
    MC_OP_STORE = 1'b1
  } mc_op_e;

  typedef enum logic [1:0] {
    MC_ST_IDLE    = 2'd0,
    MC_ST_LOOKUP  = 2'd1,
    MC_ST_FILL    = 2'd2,
    MC_ST_RESPOND = 2'd3
  } mc_cache_state_e;

endpackage

// File: hw/mc_remote_endpoint.sv
// host must not strobe while req_full_o is high, such a strobe is dropped; load ids wrap
`include "mc_consts.svh"

module mc_remote_endpoint
  import mc_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_v_i,
  input  mc_op_e                req_op_i,
  input  logic [`MC_ADDR_W-1:0] req_addr_i,
  input  logic [`MC_DATA_W-1:0] req_data_i,
  input  logic                  credit_return_i,
  output logic                  req_full_o,
  output logic                  push_o,
  output mc_op_e                push_op_o,
  output logic [`MC_ID_W-1:0]   push_id_o,
  output logic [`MC_ADDR_W-1:0] push_addr_o,
  output logic [`MC_DATA_W-1:0] push_data_o
);

  localparam int CRED_W = $clog2(`MC_FIFO_DEPTH + 1);

  logic [CRED_W-1:0]   credit_r;
  logic [`MC_ID_W-1:0] id_r;
  logic                accept;

  assign accept     = req_v_i && !req_full_o;
  assign req_full_o = (credit_r == '0);

  // a credit is spent at accept, it covers the push in flight
  always_ff @(posedge clk) begin
    if (!reset) begin
      credit_r <= CRED_W'(`MC_FIFO_DEPTH);
    end else if (accept && !credit_return_i) begin
      credit_r <= credit_r - 1'b1;
    end else if (!accept && credit_return_i) begin
      credit_r <= credit_r + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      push_o <= 1'b0;
      id_r   <= '0;
    end else begin
      push_o <= accept;
      if (accept) begin
        id_r <= id_r + 1'b1;
      end
    end
  end

  // packet payload
  always_ff @(posedge clk) begin
    if (accept) begin
      push_op_o   <= req_op_i;
      push_id_o   <= id_r;
      push_addr_o <= req_addr_i;
      push_data_o <= req_data_i;
    end
  end

endmodule

// File: hw/mc_vcache.sv
// one packet at a time; write-through, no write allocate; a load miss takes MC_DRAM_LAT+3 cycles
`include "mc_consts.svh"

module mc_vcache
  import mc_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  empty_i,
  input  mc_op_e                head_op_i,
  input  logic [`MC_ID_W-1:0]   head_id_i,
  input  logic [`MC_ADDR_W-1:0] head_addr_i,
  input  logic [`MC_DATA_W-1:0] head_data_i,
  output logic                  pop_o,
  output logic                  resp_v_o,
  output logic [`MC_ID_W-1:0]   resp_id_o,
  output mc_op_e                resp_op_o,
  output logic [`MC_DATA_W-1:0] resp_data_o,
  output logic                  resp_hit_o
);

  localparam int OFF_W = $clog2(`MC_BLOCK_WORDS);
  localparam int SET_W = $clog2(`MC_SETS);
  localparam int TAG_W = `MC_ADDR_W - SET_W - OFF_W;

  mc_cache_state_e state_r;

  // packet being served
  mc_op_e                op_r;
  logic [`MC_ID_W-1:0]   id_r;
  logic [`MC_ADDR_W-1:0] addr_r;
  logic [`MC_DATA_W-1:0] pkt_data_r;
  logic                  miss_r;

  logic [`MC_SETS-1:0]                         valid_r;
  logic [TAG_W-1:0]                            tag_mem  [`MC_SETS];
  logic [`MC_BLOCK_WORDS-1:0][`MC_DATA_W-1:0] line_mem [`MC_SETS];

  logic [SET_W-1:0] set_idx;
  logic [OFF_W-1:0] word_off;
  logic [TAG_W-1:0] tag;
  logic             hit;

  logic                                        rd_v;
  logic                                        rd_done;
  logic [`MC_BLOCK_WORDS-1:0][`MC_DATA_W-1:0] rd_block;
  logic                                        wr_v;

  assign word_off = addr_r[OFF_W-1:0];
  assign set_idx  = addr_r[OFF_W +: SET_W];
  assign tag      = addr_r[`MC_ADDR_W-1 -: TAG_W];
  assign hit      = valid_r[set_idx] && (tag_mem[set_idx] == tag);

  assign pop_o = (state_r == MC_ST_IDLE) && !empty_i;
  assign rd_v  = (state_r == MC_ST_LOOKUP) && (op_r == MC_OP_LOAD) && !hit;
  assign wr_v  = (state_r == MC_ST_LOOKUP) && (op_r == MC_OP_STORE);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r <= MC_ST_IDLE;
      miss_r  <= 1'b0;
      valid_r <= '0;
    end else begin
      case (state_r)
        MC_ST_IDLE: begin
          if (pop_o) begin
            state_r <= MC_ST_LOOKUP;
            miss_r  <= 1'b0;
          end
        end
        MC_ST_LOOKUP: begin
          if (rd_v) begin
            state_r <= MC_ST_FILL;
            miss_r  <= 1'b1;
          end else begin
            state_r <= MC_ST_RESPOND;
            // store miss reports a miss but leaves the cache alone
            if (wr_v && !hit) begin
              miss_r <= 1'b1;
            end
          end
        end
        MC_ST_FILL: begin
          // back to lookup, which now hits on the filled line
          if (rd_done) begin
            state_r          <= MC_ST_LOOKUP;
            valid_r[set_idx] <= 1'b1;
          end
        end
        default: begin
          state_r <= MC_ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      op_r       <= head_op_i;
      id_r       <= head_id_i;
      addr_r     <= head_addr_i;
      pkt_data_r <= head_data_i;
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    if (state_r == MC_ST_FILL && rd_done) begin
      tag_mem[set_idx]  <= tag;
      line_mem[set_idx] <= rd_block;
    end else if (wr_v && hit) begin
      line_mem[set_idx][word_off] <= pkt_data_r;
    end
  end

  assign resp_v_o    = (state_r == MC_ST_RESPOND);
  assign resp_id_o   = id_r;
  assign resp_op_o   = op_r;
  assign resp_hit_o  = !miss_r;
  assign resp_data_o = (op_r == MC_OP_LOAD) ? line_mem[set_idx][word_off] : pkt_data_r;

  mc_dram_model i_dram (
    .clk        (clk),
    .rd_v_i     (rd_v),
    .rd_addr_i  (addr_r[`MC_ADDR_W-1:OFF_W]),
    .rd_done_o  (rd_done),
    .rd_block_o (rd_block),
    .wr_v_i     (wr_v),
    .wr_addr_i  (addr_r),
    .wr_data_i  (pkt_data_r)
  );

endmodule

// File: verification/mc_link_fifo_checker.sv
// bound into every mc_link_fifo; checks are held off while the synchronous reset is low
`include "mc_consts.svh"

module mc_link_fifo_checker (
  input logic                                    clk,
  input logic                                    reset,
  input logic                                    push_i,
  input logic                                    pop_i,
  input logic                                    empty_i,
  input logic                                    credit_return_i,
  input logic [$clog2(`MC_FIFO_DEPTH + 1)-1:0]   count_i
);

  localparam int CNT_W = $clog2(`MC_FIFO_DEPTH + 1);

  // credits must keep the producer off a full buffer
  no_push_when_full: assert property (@(posedge clk) disable iff (!reset)
    !(push_i && (count_i == CNT_W'(`MC_FIFO_DEPTH))))
    else $error("push while the link FIFO holds %0d entries", count_i);

  no_pop_when_empty: assert property (@(posedge clk) disable iff (!reset)
    pop_i |-> !empty_i)
    else $error("pop from an empty link FIFO");

  credit_follows_pop: assert property (@(posedge clk) disable iff (!reset)
    credit_return_i == pop_i)
    else $error("credit return pulse does not match the pop strobe");

endmodule

bind mc_link_fifo mc_link_fifo_checker i_fifo_checker (
  .clk             (clk),
  .reset           (reset),
  .push_i          (push_i),
  .pop_i           (pop_i),
  .empty_i         (empty_o),
  .credit_return_i (credit_return_o),
  .count_i         (count_r)
);

// File: verification/mc_node_tb.sv
// random load/store traffic against a software mirror; the host only strobes while not full
`include "mc_consts.svh"

module mc_node_tb
  import mc_pkg::*;
();

  localparam int NUM_REQ      = 400;
  localparam int PERIOD       = 4;
  localparam int RESET_CYCLES = 8;
  localparam int OFF_W        = $clog2(`MC_BLOCK_WORDS);
  localparam int SET_W        = $clog2(`MC_SETS);
  localparam int TAG_W        = `MC_ADDR_W - SET_W - OFF_W;
  // every request a miss, then doubled
  localparam int WATCHDOG     = NUM_REQ * (`MC_DRAM_LAT + 10) * PERIOD * 2;

  logic                  clk;
  logic                  reset;
  logic                  req_v;
  mc_op_e                req_op;
  logic [`MC_ADDR_W-1:0] req_addr;
  logic [`MC_DATA_W-1:0] req_data;
  logic                  req_full;
  logic                  resp_v;
  logic [`MC_ID_W-1:0]   resp_id;
  mc_op_e                resp_op;
  logic [`MC_DATA_W-1:0] resp_data;
  logic                  resp_hit;

  // memory and cache mirrors
  logic [`MC_DATA_W-1:0] mem_mirror   [`MC_DRAM_WORDS];
  logic                  valid_mirror [`MC_SETS];
  logic [TAG_W-1:0]      tag_mirror   [`MC_SETS];

  // expected responses in request order
  logic [`MC_ID_W-1:0]   exp_id_q[$];
  mc_op_e                exp_op_q[$];
  logic [`MC_DATA_W-1:0] exp_data_q[$];
  logic                  exp_hit_q[$];
  int                    exp_cycle_q[$];

  int cycle       = 0;
  int sent        = 0;
  int received    = 0;
  int errors      = 0;
  int checks      = 0;
  int load_hits   = 0;
  int load_misses = 0;
  bit saw_full    = 1'b0;

  mc_node_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_v_i     (req_v),
    .req_op_i    (req_op),
    .req_addr_i  (req_addr),
    .req_data_i  (req_data),
    .req_full_o  (req_full),
    .resp_v_o    (resp_v),
    .resp_id_o   (resp_id),
    .resp_op_o   (resp_op),
    .resp_data_o (resp_data),
    .resp_hit_o  (resp_hit)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, got);
    end
  endtask

  // mostly two tags so lines get reused and evicted
  function automatic logic [`MC_ADDR_W-1:0] pick_addr();
    if (($urandom % 4) != 0) begin
      return `MC_ADDR_W'($urandom % 64);
    end
    return `MC_ADDR_W'($urandom);
  endfunction

  task automatic apply_to_model(input mc_op_e op, input logic [`MC_ADDR_W-1:0] addr,
                                input logic [`MC_DATA_W-1:0] data,
                                output logic [`MC_DATA_W-1:0] exp_data, output logic exp_hit);
    logic [SET_W-1:0] set;
    logic [TAG_W-1:0] tag;
    set     = addr[OFF_W +: SET_W];
    tag     = addr[`MC_ADDR_W-1 -: TAG_W];
    exp_hit = valid_mirror[set] && (tag_mirror[set] == tag);
    if (op == MC_OP_STORE) begin
      // write-through, no allocate
      mem_mirror[addr] = data;
      exp_data         = data;
    end else begin
      exp_data = mem_mirror[addr];
      if (!exp_hit) begin
        valid_mirror[set] = 1'b1;
        tag_mirror[set]   = tag;
      end
    end
  endtask

  task automatic send_request();
    mc_op_e                op;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_DATA_W-1:0] data;
    logic [`MC_DATA_W-1:0] exp_data;
    logic                  exp_hit;
    op   = (($urandom % 5) < 2) ? MC_OP_STORE : MC_OP_LOAD;
    addr = pick_addr();
    data = $urandom;
    apply_to_model(op, addr, data, exp_data, exp_hit);
    exp_id_q.push_back(`MC_ID_W'(sent));
    exp_op_q.push_back(op);
    exp_data_q.push_back(exp_data);
    exp_hit_q.push_back(exp_hit);
    // strobe is sampled at the next rising edge
    exp_cycle_q.push_back(cycle + 1);
    req_v    = 1'b1;
    req_op   = op;
    req_addr = addr;
    req_data = data;
    sent++;
  endtask

  always @(negedge clk) begin : response_monitor
    mc_op_e op;
    logic   hit;
    int     latency;
    if (reset && req_full) begin
      saw_full = 1'b1;
    end
    if (reset && resp_v) begin
      received++;
      checks++;
      assert (exp_id_q.size() > 0) else begin
        errors++;
        $display("time %0t: response arrived with no request outstanding", $time);
      end
      if (exp_id_q.size() > 0) begin
        op      = exp_op_q.pop_front();
        hit     = exp_hit_q.pop_front();
        latency = cycle - exp_cycle_q.pop_front();
        check_field("resp_id_o", 32'(exp_id_q.pop_front()), 32'(resp_id));
        check_field("resp_op_o", 32'(op), 32'(resp_op));
        check_field("resp_data_o", exp_data_q.pop_front(), resp_data);
        check_field("resp_hit_o", 32'(hit), 32'(resp_hit));
        if (op == MC_OP_LOAD) begin
          if (hit) begin
            load_hits++;
          end else begin
            load_misses++;
          end
          checks++;
          assert (latency >= (hit ? 3 : 3 + `MC_DRAM_LAT)) else begin
            errors++;
            $display("time %0t: load id %0d answered after only %0d cycles", $time, resp_id,
                     latency);
          end
        end
      end
    end
  end

  initial begin : stimulus
    void'($urandom(32'haf0f_8c66));
    reset    = 1'b0;
    req_v    = 1'b0;
    req_op   = MC_OP_LOAD;
    req_addr = '0;
    req_data = '0;
    for (int a = 0; a < `MC_DRAM_WORDS; a++) begin
      mem_mirror[a] = '0;
    end
    for (int s = 0; s < `MC_SETS; s++) begin
      valid_mirror[s] = 1'b0;
      tag_mirror[s]   = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b1;
    check_field("req_full_o", 32'd0, 32'(req_full));
    check_field("resp_v_o", 32'd0, 32'(resp_v));
    // first half at a random rate, second half as fast as credits allow
    while (sent < NUM_REQ) begin
      @(negedge clk);
      req_v = 1'b0;
      if (!req_full && (sent >= NUM_REQ / 2 || ($urandom % 3) == 0)) begin
        send_request();
      end
    end
    @(negedge clk);
    req_v = 1'b0;
    while (received < sent) begin
      @(negedge clk);
    end
    // room for a stray extra response
    repeat (2 * (`MC_DRAM_LAT + 4)) @(negedge clk);
    checks++;
    assert (received == NUM_REQ && exp_id_q.size() == 0) else begin
      errors++;
      $display("%0d requests were sent but %0d responses came back", sent, received);
    end
    checks++;
    assert (saw_full) else begin
      errors++;
      $display("req_full_o never rose, so back-pressure was not exercised");
    end
    $display("requests %0d, responses %0d, load hits %0d, load misses %0d, checks %0d, errors %0d",
             sent, received, load_hits, load_misses, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG);
    $display("timeout at %0t with %0d of %0d responses received, errors %0d", $time, received,
             NUM_REQ, errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
